//--- logic/dma_rd_pkg.sv
`default_nettype none

package dma_rd_pkg;

  // bus geometry
  localparam int DATA_WIDTH     = 64;
  localparam int BYTES_PER_BEAT = DATA_WIDTH / 8;
  localparam int SHAMT_W        = $clog2(BYTES_PER_BEAT);

  localparam int ADDR_W = 32;
  localparam int LEN_W  = 16;

  // buffer depth doubles as the internal credit pool
  localparam int META_DEPTH = 8;
  localparam int CREDIT_W   = $clog2(META_DEPTH + 1);
  localparam int PTR_W      = $clog2(META_DEPTH);

  localparam int OUT_CREDITS  = 4;
  localparam int OUT_CREDIT_W = $clog2(OUT_CREDITS + 1);

  typedef struct packed {
    logic               first;
    logic               last;
    logic [SHAMT_W-1:0] shamt;
  } beat_meta_t;

  typedef struct packed {
    logic                  first;
    logic                  last;
    logic [DATA_WIDTH-1:0] data;
  } out_beat_t;

endpackage

`default_nettype wire

//--- logic/rd_sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rd_sync_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     i_push,
  input  payload_t i_data,
  input  logic     i_pop,
  output payload_t o_data,
  output logic     o_empty
);

  import dma_rd_pkg::*;

  payload_t mem [META_DEPTH];

  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CREDIT_W-1:0] count;
  logic                do_pop;

  assign do_pop  = i_pop && !o_empty;
  assign o_empty = (count == '0);
  // head is visible without a pop
  assign o_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      count <= count + CREDIT_W'(i_push) - CREDIT_W'(do_pop);
    end
  end

endmodule

`default_nettype wire

//--- logic/rd_burst_planner.sv
`timescale 1ns/1ps
`default_nettype none

module rd_burst_planner (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          i_desc_valid,
  input  logic [dma_rd_pkg::ADDR_W-1:0] i_desc_addr,
  input  logic [dma_rd_pkg::LEN_W-1:0]  i_desc_len,
  input  logic                          i_credit_return,
  input  logic                          i_rd_valid,
  input  logic                          i_head_start,
  input  logic [dma_rd_pkg::SHAMT_W-1:0] i_head_shamt,
  input  logic                          i_align_idle,
  output logic                          o_desc_ready,
  output logic                          o_rd_req,
  output logic [dma_rd_pkg::ADDR_W-1:0] o_rd_addr,
  output logic                          o_meta_push,
  output dma_rd_pkg::beat_meta_t        o_meta,
  output logic                          o_idle
);

  import dma_rd_pkg::*;

  logic                busy;
  logic                first_r;
  logic [ADDR_W-1:0]   addr_r;
  logic [SHAMT_W-1:0]  off_r;
  logic [LEN_W-1:0]    beats_left;
  logic [CREDIT_W-1:0] credits;

  logic [SHAMT_W-1:0]  desc_off;
  logic [LEN_W-1:0]    len_m1;
  logic [LEN_W-1:0]    beats_in;
  logic                desc_take;
  logic                absorb;

  assign desc_take = i_desc_valid && o_desc_ready;
  assign desc_off  = i_desc_addr[SHAMT_W-1:0];
  assign len_m1    = i_desc_len - LEN_W'(1);
  // output beats plus one extra input beat when unaligned
  assign beats_in  = (len_m1 >> SHAMT_W) + LEN_W'(1) + LEN_W'(desc_off != '0);

  // first beat of an unaligned burst produces no output, so hand its credit back here
  assign absorb = i_rd_valid && i_head_start && (i_head_shamt != '0);

  assign o_rd_req     = busy && (credits != '0);
  assign o_rd_addr    = addr_r;
  assign o_meta_push  = o_rd_req;
  assign o_meta.first = first_r;
  assign o_meta.last  = (beats_left == LEN_W'(1));
  assign o_meta.shamt = off_r;

  assign o_desc_ready = !busy;
  assign o_idle       = !busy && (credits == CREDIT_W'(META_DEPTH)) && i_align_idle;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      first_r <= 1'b0;
    end else if (desc_take) begin
      busy    <= 1'b1;
      first_r <= 1'b1;
    end else if (o_rd_req) begin
      first_r <= 1'b0;
      if (beats_left == LEN_W'(1)) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (desc_take) begin
      addr_r     <= {i_desc_addr[ADDR_W-1:SHAMT_W], SHAMT_W'(0)};
      off_r      <= desc_off;
      beats_left <= beats_in;
    end else if (o_rd_req) begin
      addr_r     <= addr_r + ADDR_W'(BYTES_PER_BEAT);
      beats_left <= beats_left - LEN_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CREDIT_W'(META_DEPTH);
    end else begin
      credits <= credits - CREDIT_W'(o_rd_req) + CREDIT_W'(i_credit_return)
                 + CREDIT_W'(absorb);
    end
  end

endmodule

`default_nettype wire

//--- logic/read_burst_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module read_burst_aligner (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              i_valid,
  input  logic                              i_start,
  input  logic                              i_end,
  input  logic [dma_rd_pkg::DATA_WIDTH-1:0] i_data,
  input  logic [dma_rd_pkg::SHAMT_W-1:0]    i_shamt,
  output logic                              o_valid,
  output logic                              o_start,
  output logic                              o_end,
  output logic [dma_rd_pkg::DATA_WIDTH-1:0] o_data,
  output logic                              o_idle
);

  import dma_rd_pkg::*;

  typedef enum logic [1:0] {
    S_START,
    S_WAIT,
    S_END
  } state_t;

  state_t state;
  state_t nstate;

  logic [2*DATA_WIDTH-1:0] shifted;
  logic [DATA_WIDTH-1:0]   result_data;
  logic [DATA_WIDTH-1:0]   remainder_data;
  logic [DATA_WIDTH-1:0]   result_r;
  logic [SHAMT_W-1:0]      shamt_r;
  logic [SHAMT_W-1:0]      cur_shamt;
  logic                    take_first;

  assign take_first = i_valid && i_start && (state == S_START);
  // offset is sampled on the first beat and held for the rest of the burst
  assign cur_shamt  = (state == S_START) ? i_shamt : shamt_r;

  // upper bytes move down into this beat, lower bytes spill into the next one
  assign shifted = {i_data, DATA_WIDTH'(0)} >> (cur_shamt * 8);
  assign {result_data, remainder_data} = shifted;

  always_ff @(posedge clk) begin
    if (i_valid) begin
      result_r <= result_data;
    end
    if (take_first) begin
      shamt_r <= i_shamt;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_START;
    end else begin
      state <= nstate;
    end
  end

  always_comb begin
    nstate = state;
    case (state)
      S_START: begin
        if (take_first) begin
          if (i_end) begin
            nstate = S_START;
          end else if (i_shamt != '0) begin
            nstate = S_WAIT;
          end else begin
            nstate = S_END;
          end
        end
      end
      S_WAIT: begin
        if (i_valid) begin
          nstate = i_end ? S_START : S_END;
        end
      end
      S_END: begin
        if (i_valid && i_end) begin
          nstate = S_START;
        end
      end
      default: begin
        nstate = S_START;
      end
    endcase
  end

  assign o_data  = (cur_shamt == '0) ? result_data : (remainder_data | result_r);
  assign o_valid = (state == S_START) ? (take_first && (i_shamt == '0)) : i_valid;
  // with an offset the first output comes out of the wait state
  assign o_start = (state == S_START) ? (take_first && (i_shamt == '0)) :
                   (state == S_WAIT)  ? i_valid : 1'b0;
  assign o_end   = i_valid && i_end;
  assign o_idle  = (state == S_START) && !take_first;

endmodule

`default_nettype wire

//--- logic/rd_beat_sender.sv
`timescale 1ns/1ps
`default_nettype none

module rd_beat_sender (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              i_valid,
  input  logic                              i_start,
  input  logic                              i_end,
  input  logic [dma_rd_pkg::DATA_WIDTH-1:0] i_data,
  input  logic                              i_out_credit,
  output logic                              o_out_valid,
  output logic                              o_out_start,
  output logic                              o_out_end,
  output logic [dma_rd_pkg::DATA_WIDTH-1:0] o_out_data,
  output logic                              o_credit_return
);

  import dma_rd_pkg::*;

  out_beat_t             in_beat;
  out_beat_t             head;
  logic                  empty;
  logic                  send;
  logic [OUT_CREDIT_W-1:0] out_credits;

  assign in_beat.first = i_start;
  assign in_beat.last  = i_end;
  assign in_beat.data  = i_data;

  assign send = !empty && (out_credits != '0);

  rd_sync_fifo #(.payload_t(out_beat_t)) out_fifo_i (
    .clk    (clk),
    .rst    (rst),
    .i_push (i_valid),
    .i_data (in_beat),
    .i_pop  (send),
    .o_data (head),
    .o_empty(empty)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      out_credits     <= OUT_CREDIT_W'(OUT_CREDITS);
      o_out_valid     <= 1'b0;
      o_credit_return <= 1'b0;
    end else begin
      out_credits     <= out_credits - OUT_CREDIT_W'(send) + OUT_CREDIT_W'(i_out_credit);
      o_out_valid     <= send;
      o_credit_return <= send;
    end
  end

  // payload only means something while o_out_valid is high
  always_ff @(posedge clk) begin
    if (send) begin
      o_out_start <= head.first;
      o_out_end   <= head.last;
      o_out_data  <= head.data;
    end
  end

endmodule

`default_nettype wire

//--- logic/dma_rd_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_rd_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              i_desc_valid,
  input  logic [dma_rd_pkg::ADDR_W-1:0]     i_desc_addr,
  input  logic [dma_rd_pkg::LEN_W-1:0]      i_desc_len,
  output logic                              o_desc_ready,
  output logic                              o_rd_req,
  output logic [dma_rd_pkg::ADDR_W-1:0]     o_rd_addr,
  input  logic                              i_rd_valid,
  input  logic [dma_rd_pkg::DATA_WIDTH-1:0] i_rd_data,
  output logic                              o_out_valid,
  output logic                              o_out_start,
  output logic                              o_out_end,
  output logic [dma_rd_pkg::DATA_WIDTH-1:0] o_out_data,
  input  logic                              i_out_credit,
  output logic                              o_credit_return,
  output logic                              o_idle
);

  import dma_rd_pkg::*;

  logic                  meta_push;
  beat_meta_t            meta_in;
  beat_meta_t            meta_head;
  logic                  align_valid;
  logic                  align_start;
  logic                  align_end;
  logic [DATA_WIDTH-1:0] align_data;
  logic                  align_idle;

  rd_burst_planner planner_i (
    .clk            (clk),
    .rst            (rst),
    .i_desc_valid   (i_desc_valid),
    .i_desc_addr    (i_desc_addr),
    .i_desc_len     (i_desc_len),
    .i_credit_return(o_credit_return),
    .i_rd_valid     (i_rd_valid),
    .i_head_start   (meta_head.first),
    .i_head_shamt   (meta_head.shamt),
    .i_align_idle   (align_idle),
    .o_desc_ready   (o_desc_ready),
    .o_rd_req       (o_rd_req),
    .o_rd_addr      (o_rd_addr),
    .o_meta_push    (meta_push),
    .o_meta         (meta_in),
    .o_idle         (o_idle)
  );

  // memory answers in order, so the head always belongs to the arriving beat
  rd_sync_fifo #(.payload_t(beat_meta_t)) meta_fifo_i (
    .clk    (clk),
    .rst    (rst),
    .i_push (meta_push),
    .i_data (meta_in),
    .i_pop  (i_rd_valid),
    .o_data (meta_head),
    .o_empty()
  );

  read_burst_aligner aligner_i (
    .clk    (clk),
    .rst    (rst),
    .i_valid(i_rd_valid),
    .i_start(meta_head.first),
    .i_end  (meta_head.last),
    .i_data (i_rd_data),
    .i_shamt(meta_head.shamt),
    .o_valid(align_valid),
    .o_start(align_start),
    .o_end  (align_end),
    .o_data (align_data),
    .o_idle (align_idle)
  );

  rd_beat_sender sender_i (
    .clk            (clk),
    .rst            (rst),
    .i_valid        (align_valid),
    .i_start        (align_start),
    .i_end          (align_end),
    .i_data         (align_data),
    .i_out_credit   (i_out_credit),
    .o_out_valid    (o_out_valid),
    .o_out_start    (o_out_start),
    .o_out_end      (o_out_end),
    .o_out_data     (o_out_data),
    .o_credit_return(o_credit_return)
  );

endmodule

`default_nettype wire

//--- sim/dma_rd_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dma_rd_checker (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              i_desc_valid,
  input  logic                              i_desc_ready,
  input  logic [dma_rd_pkg::ADDR_W-1:0]     i_desc_addr,
  input  logic [dma_rd_pkg::LEN_W-1:0]      i_desc_len,
  input  logic                              i_out_valid,
  input  logic                              i_out_start,
  input  logic                              i_out_end,
  input  logic [dma_rd_pkg::DATA_WIDTH-1:0] i_out_data,
  input  logic                              i_out_credit,
  output int                                o_pending,
  output int                                o_errors
);

  import dma_rd_pkg::*;

  typedef struct packed {
    int                desc;
    int                beat;
    logic [ADDR_W-1:0] addr;
    int                nbytes;
    logic              first;
    logic              last;
  } exp_beat_t;

  exp_beat_t exp_q[$];
  int        desc_count;
  int        outstanding;

  function automatic logic [7:0] expected_byte(input logic [ADDR_W-1:0] a);
    return 8'(a * 7 + 3);
  endfunction

  always @(posedge clk) begin
    exp_beat_t             e;
    int                    m;
    int                    left;
    logic [DATA_WIDTH-1:0] exp_w;
    logic [DATA_WIDTH-1:0] mask;
    if (!rst) begin
      if (i_out_valid) begin
        outstanding++;
        if (exp_q.size() == 0) begin
          $display("extra output beat with no descriptor pending, data %h", i_out_data);
          o_errors++;
        end else begin
          e     = exp_q.pop_front();
          exp_w = '0;
          mask  = '0;
          // bytes past the length are left unchecked
          for (int k = 0; k < e.nbytes; k++) begin
            exp_w[k*8 +: 8] = expected_byte(e.addr + ADDR_W'(k));
            mask[k*8 +: 8]  = 8'hff;
          end
          if ((i_out_data & mask) !== exp_w) begin
            $display("ERROR case_%0d beat %0d data: expected %h, actual %h",
                     e.desc, e.beat, exp_w, i_out_data & mask);
            o_errors++;
          end
          if (i_out_start !== e.first) begin
            $display("ERROR case_%0d beat %0d start: expected %0b, actual %0b",
                     e.desc, e.beat, e.first, i_out_start);
            o_errors++;
          end
          if (i_out_end !== e.last) begin
            $display("ERROR case_%0d beat %0d end: expected %0b, actual %0b",
                     e.desc, e.beat, e.last, i_out_end);
            o_errors++;
          end
        end
      end
      if (i_out_credit) begin
        outstanding--;
      end
      if (outstanding > OUT_CREDITS) begin
        $display("%0d output beats outstanding, more than the %0d credits allow",
                 outstanding, OUT_CREDITS);
        o_errors++;
      end
      if (i_desc_valid && i_desc_ready) begin
        m = (int'(i_desc_len) + BYTES_PER_BEAT - 1) / BYTES_PER_BEAT;
        for (int j = 0; j < m; j++) begin
          left     = int'(i_desc_len) - j * BYTES_PER_BEAT;
          e.desc   = desc_count;
          e.beat   = j;
          e.addr   = i_desc_addr + ADDR_W'(j * BYTES_PER_BEAT);
          e.nbytes = (left > BYTES_PER_BEAT) ? BYTES_PER_BEAT : left;
          e.first  = (j == 0);
          e.last   = (j == m - 1);
          exp_q.push_back(e);
        end
        desc_count++;
      end
    end
    o_pending = exp_q.size();
  end

endmodule

`default_nettype wire

//--- sim/tb_dma_rd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dma_rd;

  import dma_rd_pkg::*;

  logic                  clk;
  logic                  rst;
  logic                  desc_valid;
  logic [ADDR_W-1:0]     desc_addr;
  logic [LEN_W-1:0]      desc_len;
  logic                  desc_ready;
  logic                  rd_req;
  logic [ADDR_W-1:0]     rd_addr;
  logic                  rd_valid = 1'b0;
  logic [DATA_WIDTH-1:0] rd_data = '0;
  logic                  out_valid;
  logic                  out_start;
  logic                  out_end;
  logic [DATA_WIDTH-1:0] out_data;
  logic                  out_credit = 1'b0;
  logic                  credit_return;
  logic                  idle;

  logic [ADDR_W-1:0] case_addr[$];
  int                case_len[$];
  int                case_delay[$];

  int         cycle = 0;
  int         last_due = 0;
  logic [7:0] lfsr = 8'd85;
  int         resp_due[$];
  logic [ADDR_W-1:0] resp_addr[$];
  int         credit_due[$];
  int         cur_delay;
  int         cur_case;
  int         wd_limit;
  logic       loaded = 1'b0;
  int         flow_errors;
  int         check_errors;
  int         pending;

  dma_rd_top dut_i (
    .clk            (clk),
    .rst            (rst),
    .i_desc_valid   (desc_valid),
    .i_desc_addr    (desc_addr),
    .i_desc_len     (desc_len),
    .o_desc_ready   (desc_ready),
    .o_rd_req       (rd_req),
    .o_rd_addr      (rd_addr),
    .i_rd_valid     (rd_valid),
    .i_rd_data      (rd_data),
    .o_out_valid    (out_valid),
    .o_out_start    (out_start),
    .o_out_end      (out_end),
    .o_out_data     (out_data),
    .i_out_credit   (out_credit),
    .o_credit_return(credit_return),
    .o_idle         (idle)
  );

  dma_rd_checker checker_i (
    .clk         (clk),
    .rst         (rst),
    .i_desc_valid(desc_valid),
    .i_desc_ready(desc_ready),
    .i_desc_addr (desc_addr),
    .i_desc_len  (desc_len),
    .i_out_valid (out_valid),
    .i_out_start (out_start),
    .i_out_end   (out_end),
    .i_out_data  (out_data),
    .i_out_credit(out_credit),
    .o_pending   (pending),
    .o_errors    (check_errors)
  );

  function automatic logic [7:0] mem_byte(input logic [ADDR_W-1:0] a);
    return 8'(a * 7 + 3);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] mem_beat(input logic [ADDR_W-1:0] a);
    logic [DATA_WIDTH-1:0] w;
    w = '0;
    for (int k = 0; k < BYTES_PER_BEAT; k++) begin
      w[k*8 +: 8] = mem_byte(a + ADDR_W'(k));
    end
    return w;
  endfunction

  // galois form of x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %s: expected %0b, actual %0b", what, exp, act);
      flow_errors++;
    end
  endtask

  task automatic load_cases();
    int                fd;
    int                n;
    string             tok;
    string             rest;
    logic [ADDR_W-1:0] a;
    int                len;
    int                dly;
    fd = $fopen("sim/dma_rd_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open case file sim/dma_rd_cases.txt");
      flow_errors++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok.getc(0) == "#") begin
          n = $fgets(rest, fd);
        end else begin
          n = $sscanf(tok, "%h", a);
          n = n + $fscanf(fd, "%d %d", len, dly);
          if (n != 3 || len < 1) begin
            $display("malformed line in case file near %s", tok);
            flow_errors++;
          end else begin
            case_addr.push_back(a);
            case_len.push_back(len);
            case_delay.push_back(dly);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // in-order memory answering 1 to 4 cycles after each request
  always @(negedge clk) begin
    int d;
    int due;
    rd_valid <= 1'b0;
    if (resp_due.size() > 0 && resp_due[0] == cycle) begin
      rd_valid <= 1'b1;
      rd_data  <= mem_beat(resp_addr[0]);
      void'(resp_due.pop_front());
      void'(resp_addr.pop_front());
    end
    if (rd_req === 1'b1) begin
      draw_bits(2, d);
      due = cycle + 1 + d;
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      resp_due.push_back(due);
      resp_addr.push_back(rd_addr);
    end
  end

  // one credit back per received beat once the case delay has passed
  always @(negedge clk) begin
    out_credit <= 1'b0;
    if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
      out_credit <= 1'b1;
      void'(credit_due.pop_front());
    end
    if (out_valid === 1'b1) begin
      credit_due.push_back(cycle + cur_delay);
    end
  end

  initial begin
    wait (loaded);
    repeat (wd_limit) @(negedge clk);
    $display("timeout: run did not finish within %0d cycles, stuck in case_%0d",
             wd_limit, cur_case);
    $display("errors: %0d output, %0d flow", check_errors, flow_errors + 1);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    rst         = 1'b1;
    desc_valid  = 1'b0;
    desc_addr   = '0;
    desc_len    = '0;
    cur_delay   = 1;
    cur_case    = -1;
    flow_errors = 0;
    load_cases();
    if (case_addr.size() == 0) begin
      $display("no descriptors were read from the case file");
      flow_errors++;
    end
    wd_limit = 200;
    foreach (case_len[i]) begin
      wd_limit += 40 * ((case_len[i] + BYTES_PER_BEAT - 1) / BYTES_PER_BEAT);
    end
    loaded = 1'b1;

    repeat (4) @(negedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_flag("reset o_rd_req", 1'b0, rd_req);
    check_flag("reset o_out_valid", 1'b0, out_valid);
    check_flag("reset o_credit_return", 1'b0, credit_return);
    check_flag("reset o_desc_ready", 1'b1, desc_ready);
    check_flag("reset o_idle", 1'b1, idle);

    for (int i = 0; i < case_addr.size(); i++) begin
      cur_case   = i;
      cur_delay  = case_delay[i];
      desc_valid <= 1'b1;
      desc_addr  <= case_addr[i];
      desc_len   <= LEN_W'(case_len[i]);
      @(negedge clk);
      desc_valid <= 1'b0;
      // done once the DUT is idle and every output credit has gone back
      do begin
        @(posedge clk);
      end while (!(idle === 1'b1 && credit_due.size() == 0));
      @(negedge clk);
      if (pending != 0) begin
        $display("case_%0d went idle with %0d output beats missing", i, pending);
        flow_errors++;
      end
      check_flag($sformatf("case_%0d o_desc_ready when idle", i), 1'b1, desc_ready);
    end

    repeat (2) @(negedge clk);
    $display("errors: %0d output, %0d flow", check_errors, flow_errors);
    if (check_errors == 0 && flow_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/dma_rd_cases.txt
# start address (hex), length in bytes, cycles before each output credit is returned
# one descriptor per line, issued in order
00001000 8 1
00001000 64 2
00001001 15 1
00001007 20 3
00001003 1 1
00001007 1 2
0000200f 37 1
00002005 100 30
00003000 72 25
00003006 9 4
00004002 8 2
0000500c 250 6
00006000 16 1

//--- vlog.f
logic/dma_rd_pkg.sv
logic/rd_sync_fifo.sv
logic/rd_burst_planner.sv
logic/read_burst_aligner.sv
logic/rd_beat_sender.sv
logic/dma_rd_top.sv
sim/dma_rd_checker.sv
sim/tb_dma_rd.sv

//--- Makefile
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module tb_dma_rd

sim:
	verilator --binary --timing -f vlog.f --top-module tb_dma_rd -Mdir obj_dir -o sim_dma_rd
	./obj_dir/sim_dma_rd | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
